/* Makefile */
SIM      := verilator
SIMFLAGS := --binary --timing --assert
TOP      := adc_capture_tb
FILELIST := adc_capture_top.f
BUILDDIR := obj_dir

BIN      := $(BUILDDIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(BUILDDIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf $(BUILDDIR)

/* adc_capture_top.f */
source/capture_pkg.sv
source/readout_pkg.sv
source/sample_fifo.sv
source/capture_fsm.sv
source/sample_packer.sv
source/byte_reader.sv
source/adc_capture_top.sv
test/adc_capture_tb.sv

/* source/adc_capture_top.sv */
`timescale 1ns/100ps
`default_nettype none

module adc_capture_top
    import capture_pkg::*;
    import readout_pkg::*;
(
    input  logic         adc_sampleclk,
    input  logic         reset,
    input  sample_t      adc_datain_i,
    input  logic         adc_write_mask_i,
    input  logic         adc_capture_go_i,
    input  logic         arm_i,
    input  capture_cfg_t cfg_i,
    input  read_mode_t   read_mode_i,
    input  logic         fifo_read_fifoen_i,
    output logic [7:0]   fifo_read_data_o,
    output logic         fifo_read_fifoempty_o,
    output logic         adc_capture_stop_o,
    output logic         error_flag_o
);

    logic         fifo_clear;
    logic         sample_push;
    logic         sample_drain;     // presample window discard
    logic         sample_pop;       // packer read after trigger
    logic         draining;
    logic         word_push;
    logic         word_pop;
    sample_t      sample_dout;
    word_t        packed_word;
    word_t        word_dout;
    fifo_status_t sample_st;
    fifo_status_t word_st;

    assign fifo_read_fifoempty_o = word_st.empty;

    capture_fsm u_capture_fsm (
        .adc_sampleclk      (adc_sampleclk),
        .reset              (reset),
        .arm_i              (arm_i),
        .adc_capture_go_i   (adc_capture_go_i),
        .adc_write_mask_i   (adc_write_mask_i),
        .cfg_i              (cfg_i),
        .fifo_st_i          (sample_st),
        .push_o             (sample_push),
        .drain_o            (sample_drain),
        .fifo_clear_o       (fifo_clear),
        .draining_o         (draining),
        .adc_capture_stop_o (adc_capture_stop_o)
    );

    sample_fifo #(
        .payload_t (sample_t),
        .DEPTH     (SAMPLE_FIFO_DEPTH)
    ) u_sample_fifo (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .clear_i       (fifo_clear),
        .push_i        (sample_push),
        .din_i         (adc_datain_i),
        .pop_i         (sample_drain | sample_pop),  // never both, drain ends at the trigger
        .dout_o        (sample_dout),
        .status_o      (sample_st)
    );

    sample_packer u_sample_packer (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .draining_i    (draining),
        .sample_i      (sample_dout),
        .sample_st_i   (sample_st),
        .sample_pop_o  (sample_pop),
        .word_st_i     (word_st),
        .word_push_o   (word_push),
        .word_o        (packed_word),
        .fifo_clear_i  (fifo_clear)
    );

    sample_fifo #(
        .payload_t (word_t),
        .DEPTH     (WORD_FIFO_DEPTH)
    ) u_word_fifo (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .clear_i       (fifo_clear),
        .push_i        (word_push),
        .din_i         (packed_word),
        .pop_i         (word_pop),
        .dout_o        (word_dout),
        .status_o      (word_st)
    );

    byte_reader u_byte_reader (
        .adc_sampleclk      (adc_sampleclk),
        .reset              (reset),
        .read_mode_i        (read_mode_i),
        .fifo_read_fifoen_i (fifo_read_fifoen_i),
        .word_i             (word_dout),
        .word_st_i          (word_st),
        .word_pop_o         (word_pop),
        .sample_st_i        (sample_st),
        .fifo_clear_i       (fifo_clear),
        .fifo_read_data_o   (fifo_read_data_o),
        .error_flag_o       (error_flag_o)
    );

endmodule

`default_nettype wire

/* source/byte_reader.sv */
`timescale 1ns/100ps
`default_nettype none

module byte_reader
    import capture_pkg::*;
    import readout_pkg::*;
(
    input  logic         adc_sampleclk,
    input  logic         reset,
    input  read_mode_t   read_mode_i,
    input  logic         fifo_read_fifoen_i,
    input  word_t        word_i,
    input  fifo_status_t word_st_i,
    output logic         word_pop_o,
    input  fifo_status_t sample_st_i,
    input  logic         fifo_clear_i,
    output logic [7:0]   fifo_read_data_o,
    output logic         error_flag_o
);

    logic [3:0] byte_idx;
    logic [3:0] last_idx;
    logic       split_pop;  // end of the first word in hi-res
    logic [3:0] nibble_r;   // word 0 tail for the split byte
    logic       bad_read;
    logic       bad_read_r; // host broke the handshake
    logic [7:0] hi_byte;
    logic [7:0] lo_byte;

    assign last_idx   = read_mode_i.low_res ? 4'(LO_RES_BYTES - 1) : 4'(HI_RES_BYTES - 1);
    assign split_pop  = fifo_read_fifoen_i && !read_mode_i.low_res
                     && (byte_idx == 4'(HI_RES_SPLIT - 1));
    assign word_pop_o = (fifo_read_fifoen_i && (byte_idx == last_idx)) || split_pop;
    assign bad_read   = fifo_read_fifoen_i && word_st_i.empty;

    always_ff @(posedge adc_sampleclk) begin
        if (reset || fifo_clear_i) begin
            byte_idx     <= '0;
            bad_read_r   <= 1'b0;
            error_flag_o <= 1'b0;
        end else begin
            if (fifo_read_fifoen_i) begin
                byte_idx <= (byte_idx == last_idx) ? '0 : byte_idx + 1'b1;
            end
            if (bad_read) begin
                bad_read_r <= 1'b1;
            end
            if (bad_read || word_st_i.overflow || word_st_i.underflow
                    || sample_st_i.overflow || sample_st_i.underflow) begin
                error_flag_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (split_pop) begin
            nibble_r <= word_i[3:0];
        end
    end

    // nine bytes over two words
    always_comb begin
        case (byte_idx)
            4'd0:    hi_byte = word_i[35:28];
            4'd1:    hi_byte = word_i[27:20];
            4'd2:    hi_byte = word_i[19:12];
            4'd3:    hi_byte = word_i[11:4];
            4'd4:    hi_byte = {nibble_r, word_i[35:32]};
            4'd5:    hi_byte = word_i[31:24];
            4'd6:    hi_byte = word_i[23:16];
            4'd7:    hi_byte = word_i[15:8];
            4'd8:    hi_byte = word_i[7:0];
            default: hi_byte = 8'h00;
        endcase
    end

    always_comb begin
        lo_byte = 8'h00;
        for (int k = 0; k < SAMPLES_PER_WORD; k++) begin
            if (byte_idx == 4'(k)) begin
                lo_byte = word_i[(SAMPLES_PER_WORD-1-k)*SAMPLE_W + (SAMPLE_W-8) +: 8];
            end
        end
    end

    assign fifo_read_data_o = bad_read_r ? 8'h00
                            : (read_mode_i.low_res ? lo_byte : hi_byte);

endmodule

`default_nettype wire

/* source/capture_fsm.sv */
`timescale 1ns/100ps
`default_nettype none

module capture_fsm
    import capture_pkg::*;
(
    input  logic         adc_sampleclk,
    input  logic         reset,
    input  logic         arm_i,
    input  logic         adc_capture_go_i,
    input  logic         adc_write_mask_i,
    input  capture_cfg_t cfg_i,
    input  fifo_status_t fifo_st_i,
    output logic         push_o,
    output logic         drain_o,
    output logic         fifo_clear_o,
    output logic         draining_o,
    output logic         adc_capture_stop_o
);

    capture_state_t state;
    capture_state_t trig_state;
    logic [7:0]     ds_cnt;
    logic           ds_wrap;
    logic           arm_r;
    logic           armed;      // idle waits for a trigger only after an arm
    logic           capturing;
    logic [16:0]    kept_cnt;   // samples held for this capture, presamples included
    logic [16:0]    kept_next;
    logic [16:0]    target;
    logic [2:0]     quantum_rem;

    assign ds_wrap = (ds_cnt == cfg_i.downsample);

    always_ff @(posedge adc_sampleclk) begin
        if (reset || fifo_clear_o || ds_wrap) begin
            ds_cnt <= '0;
        end else begin
            ds_cnt <= ds_cnt + 1'b1;
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            arm_r        <= 1'b0;
            fifo_clear_o <= 1'b0;
        end else begin
            arm_r        <= arm_i;
            fifo_clear_o <= arm_i && !arm_r;
        end
    end

    // max_samples rounded up to the capture quantum
    assign quantum_rem = 3'(cfg_i.max_samples % CAPTURE_QUANTUM);
    assign target = (quantum_rem == 3'd0) ? {1'b0, cfg_i.max_samples}
                  : {1'b0, cfg_i.max_samples} + 17'(CAPTURE_QUANTUM - quantum_rem);

    assign capturing  = (state == ST_PRESAMP_FILLING) || (state == ST_PRESAMP_FULL)
                     || (state == ST_TRIGGERED);
    assign push_o     = ds_wrap && adc_write_mask_i && capturing;
    assign drain_o    = push_o && (state == ST_PRESAMP_FULL); // keeps the window size fixed
    assign kept_next  = (push_o && !drain_o) ? kept_cnt + 1'b1 : kept_cnt;
    assign trig_state = (kept_next >= target) ? ST_DONE : ST_TRIGGERED;
    assign draining_o = (state == ST_TRIGGERED) || (state == ST_DONE);

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            state              <= ST_IDLE;
            kept_cnt           <= '0;
            armed              <= 1'b0;
            adc_capture_stop_o <= 1'b0;
        end else if (fifo_clear_o) begin
            kept_cnt           <= '0;
            armed              <= 1'b1;
            adc_capture_stop_o <= 1'b0;
            state <= (cfg_i.presamples != '0) ? ST_PRESAMP_FILLING : ST_IDLE;
        end else begin
            kept_cnt <= kept_next;
            if (state != ST_IDLE) begin
                armed <= 1'b0;
            end
            case (state)
                ST_IDLE: begin
                    if (armed && (cfg_i.presamples == '0) && adc_capture_go_i) begin
                        state <= trig_state;
                    end
                end
                ST_PRESAMP_FILLING: begin
                    if (adc_capture_go_i) begin
                        state <= trig_state;
                    end else if (kept_next == {1'b0, cfg_i.presamples}) begin
                        state <= ST_PRESAMP_FULL;
                    end
                end
                ST_PRESAMP_FULL: begin
                    if (adc_capture_go_i) begin
                        state <= trig_state;
                    end
                end
                ST_TRIGGERED: begin
                    if (kept_next >= target) begin
                        state <= ST_DONE;
                    end
                end
                ST_DONE: begin
                    if (fifo_st_i.empty) begin
                        adc_capture_stop_o <= 1'b1;  // packer has taken the last sample
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // the window count tracks the FIFO, so a drain always finds data
    drain_nonempty_a: assert property (@(posedge adc_sampleclk) disable iff (reset)
        drain_o |-> !fifo_st_i.empty);

endmodule

`default_nettype wire

/* source/capture_pkg.sv */
`default_nettype none

package capture_pkg;

    localparam int SAMPLE_W          = 12;
    localparam int SAMPLE_FIFO_DEPTH = 64;
    localparam int CAPTURE_QUANTUM   = 6;   // two packed words

    typedef logic [SAMPLE_W-1:0] sample_t;

    typedef struct packed {
        logic [15:0] presamples;
        logic [15:0] max_samples;
        logic [7:0]  downsample;    // 0 keeps every sample
    } capture_cfg_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_PRESAMP_FILLING,
        ST_PRESAMP_FULL,
        ST_TRIGGERED,
        ST_DONE
    } capture_state_t;

    typedef struct packed {
        logic full;
        logic empty;
        logic overflow;     // pulses when a push is dropped
        logic underflow;    // pulses when a pop is dropped
    } fifo_status_t;

endpackage

`default_nettype wire

/* source/readout_pkg.sv */
`default_nettype none

package readout_pkg;

    localparam int SAMPLES_PER_WORD = 3;
    localparam int WORD_FIFO_DEPTH  = 32;

    // host byte slots
    localparam int LO_RES_BYTES = 3;    // upper 8 bits of each sample in one word
    localparam int HI_RES_BYTES = 9;    // full samples spread over two words
    localparam int HI_RES_SPLIT = 4;    // slot built from word 0 tail and word 1 head

    // oldest sample sits in the top 12 bits
    typedef logic [SAMPLES_PER_WORD*capture_pkg::SAMPLE_W-1:0] word_t;

    typedef struct packed {
        logic low_res;
    } read_mode_t;

endpackage

`default_nettype wire

/* source/sample_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

module sample_fifo
    import capture_pkg::*;
#(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 16
) (
    input  logic         adc_sampleclk,
    input  logic         reset,
    input  logic         clear_i,
    input  logic         push_i,
    input  payload_t     din_i,
    input  logic         pop_i,
    output payload_t     dout_o,
    output fifo_status_t status_o
);

    payload_t                   mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]   wr_ptr;     // depth is a power of two, pointers wrap by themselves
    logic [$clog2(DEPTH)-1:0]   rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;
    logic                       fifo_full;
    logic                       fifo_empty;
    logic                       do_push;
    logic                       do_pop;
    logic                       ovf_r;
    logic                       unf_r;

    assign fifo_full  = (count == ($clog2(DEPTH+1))'(DEPTH));
    assign fifo_empty = (count == '0);
    assign do_pop     = pop_i && !fifo_empty;
    assign do_push    = push_i && (!fifo_full || do_pop);   // full still takes a paired push

    assign dout_o   = mem[rd_ptr];
    assign status_o = '{full: fifo_full, empty: fifo_empty, overflow: ovf_r, underflow: unf_r};

    always_ff @(posedge adc_sampleclk) begin
        if (reset || clear_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            ovf_r  <= 1'b0;
            unf_r  <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            ovf_r <= push_i && !do_push;
            unf_r <= pop_i && !do_pop;
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (do_push) begin
            mem[wr_ptr] <= din_i;
        end
    end

    // occupancy stays in range over any sequence of push, pop and clear
    count_bound_a: assert property (@(posedge adc_sampleclk) disable iff (reset)
        count <= ($clog2(DEPTH+1))'(DEPTH));

endmodule

`default_nettype wire

/* source/sample_packer.sv */
`timescale 1ns/100ps
`default_nettype none

module sample_packer
    import capture_pkg::*;
    import readout_pkg::*;
(
    input  logic         adc_sampleclk,
    input  logic         reset,
    input  logic         draining_i,
    input  sample_t      sample_i,
    input  fifo_status_t sample_st_i,
    output logic         sample_pop_o,
    input  fifo_status_t word_st_i,
    output logic         word_push_o,
    output word_t        word_o,
    input  logic         fifo_clear_i
);

    logic [1:0] slot;       // samples already in the current word
    logic       last_slot;
    word_t      shift_r;

    assign sample_pop_o = draining_i && !sample_st_i.empty && !word_st_i.full;
    assign last_slot    = (slot == 2'(SAMPLES_PER_WORD - 1));
    assign word_o       = shift_r;

    always_ff @(posedge adc_sampleclk) begin
        if (reset || fifo_clear_i) begin
            slot        <= '0;
            word_push_o <= 1'b0;
        end else begin
            word_push_o <= sample_pop_o && last_slot;
            if (sample_pop_o) begin
                slot <= last_slot ? '0 : slot + 1'b1;
            end
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (sample_pop_o) begin
            shift_r <= {shift_r[$bits(word_t)-SAMPLE_W-1:0], sample_i};  // oldest drifts to the top
        end
    end

    // reads stall on a full word FIFO, so the delayed push always has room
    push_room_a: assert property (@(posedge adc_sampleclk) disable iff (reset)
        word_push_o |-> !word_st_i.full);

endmodule

`default_nettype wire

/* test/adc_capture_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module adc_capture_tb
    import capture_pkg::*;
    import readout_pkg::*;
;

    localparam int CLK_PERIOD = 40;
    localparam int NUM_ROWS   = 7;

    typedef struct packed {
        logic [15:0] presamples;
        logic [15:0] max_samples;
        logic [7:0]  downsample;
        logic        low_res;
        logic [15:0] trig_delay;    // cycles from window start to trigger
        logic        extra_read;    // strobe once more on an empty FIFO
        logic [15:0] exp_samples;   // max_samples rounded up to a multiple of six
    } test_row_t;

    // rows 1 and 2 share a config, one per read mode
    test_row_t rows [NUM_ROWS] = '{
        '{16'd0,  16'd12, 8'd0, 1'b0, 16'd5,  1'b0, 16'd12},
        '{16'd8,  16'd30, 8'd1, 1'b0, 16'd40, 1'b1, 16'd30},
        '{16'd8,  16'd30, 8'd1, 1'b1, 16'd40, 1'b0, 16'd30},
        '{16'd5,  16'd40, 8'd2, 1'b1, 16'd30, 1'b1, 16'd42},
        '{16'd20, 16'd93, 8'd0, 1'b0, 16'd60, 1'b0, 16'd96},   // fills the word FIFO
        '{16'd3,  16'd7,  8'd3, 1'b1, 16'd25, 1'b1, 16'd12},
        '{16'd0,  16'd1,  8'd5, 1'b0, 16'd3,  1'b0, 16'd6}
    };

    logic         adc_sampleclk = 1'b0;
    logic         reset = 1'b1;
    sample_t      adc_datain_i = '0;
    logic         adc_write_mask_i = 1'b1;
    logic         adc_capture_go_i = 1'b0;
    logic         arm_i = 1'b0;
    capture_cfg_t cfg_i = '0;
    read_mode_t   read_mode_i = '0;
    logic         fifo_read_fifoen_i = 1'b0;
    logic [7:0]   fifo_read_data_o;
    logic         fifo_read_fifoempty_o;
    logic         adc_capture_stop_o;
    logic         error_flag_o;

    integer       seed = 32'hb31e;
    int           row_errs;
    int           tests_passed;
    int           tests_failed;
    logic [7:0]   rd_bytes [$];
    logic [11:0]  rd_vals [$];     // full samples, or upper bytes in lo-res

    adc_capture_top DUT (
        .adc_sampleclk         (adc_sampleclk),
        .reset                 (reset),
        .adc_datain_i          (adc_datain_i),
        .adc_write_mask_i      (adc_write_mask_i),
        .adc_capture_go_i      (adc_capture_go_i),
        .arm_i                 (arm_i),
        .cfg_i                 (cfg_i),
        .read_mode_i           (read_mode_i),
        .fifo_read_fifoen_i    (fifo_read_fifoen_i),
        .fifo_read_data_o      (fifo_read_data_o),
        .fifo_read_fifoempty_o (fifo_read_fifoempty_o),
        .adc_capture_stop_o    (adc_capture_stop_o),
        .error_flag_o          (error_flag_o)
    );

    always #(CLK_PERIOD/2) adc_sampleclk = ~adc_sampleclk;

    always @(posedge adc_sampleclk) begin
        adc_datain_i <= adc_datain_i + 1'b1;   // free-running ramp
    end

    function automatic logic [11:0] ramp_sample(input logic [11:0] base, input int idx,
                                                input int step);
        return 12'(int'(base) + idx * step);
    endfunction

    // what the host sees of one sample
    function automatic logic [11:0] visible_bits(input logic [11:0] s, input logic low_res);
        return low_res ? {4'h0, s[11:4]} : s;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%h expected 0x%h", what, got, exp);
            row_errs++;
        end
    endtask

    task automatic report_test(input string name);
        if (row_errs == 0) begin
            tests_passed++;
        end else begin
            tests_failed++;
        end
        $display("test %s: %s", name, (row_errs == 0) ? "pass" : "fail");
    endtask

    task automatic read_until_empty();
        int   gap;
        logic done;
        done = 1'b0;
        rd_bytes.delete();
        while (!done) begin
            @(negedge adc_sampleclk);
            if (fifo_read_fifoempty_o) begin
                done = 1'b1;
            end else begin
                rd_bytes.push_back(fifo_read_data_o);  // valid ahead of the strobe
                @(posedge adc_sampleclk);
                fifo_read_fifoen_i <= 1'b1;
                @(posedge adc_sampleclk);
                fifo_read_fifoen_i <= 1'b0;
                gap = $random(seed) & 3;
                repeat (gap) @(posedge adc_sampleclk);
            end
        end
    endtask

    // nine hi-res bytes carry six samples, oldest first
    task automatic decode_samples(input logic low_res);
        logic [71:0] group;
        group = '0;
        rd_vals.delete();
        for (int i = 0; i < rd_bytes.size(); i++) begin
            if (low_res) begin
                rd_vals.push_back({4'h0, rd_bytes[i]});
            end else begin
                group = {group[63:0], rd_bytes[i]};
                if (i % HI_RES_BYTES == HI_RES_BYTES - 1) begin
                    for (int k = 5; k >= 0; k--) begin
                        rd_vals.push_back(group[k*12 +: 12]);
                    end
                end
            end
        end
    endtask

    task automatic check_capture(input test_row_t row, input logic [11:0] trig_val);
        int          step;
        int          target;
        int          exp_bytes;
        int          anchor;
        logic [11:0] base;
        logic        hit;
        step      = int'(row.downsample) + 1;
        target    = int'(row.exp_samples);
        exp_bytes = row.low_res ? target : target / CAPTURE_QUANTUM * HI_RES_BYTES;
        check_value("fifo_read_data_o byte count", rd_bytes.size(), exp_bytes);
        // sample P may sit 0..step ramp values past the trigger value
        anchor = 0;
        hit    = 1'b0;
        for (int c = 0; c <= step && !hit; c++) begin
            base = 12'(int'(trig_val) + c - int'(row.presamples) * step);
            hit  = 1'b1;
            for (int i = 0; i < rd_vals.size(); i++) begin
                if (rd_vals[i] != visible_bits(ramp_sample(base, i, step), row.low_res)) begin
                    hit = 1'b0;
                end
            end
            if (hit) begin
                anchor = c;
            end
        end
        base = 12'(int'(trig_val) + anchor - int'(row.presamples) * step);
        for (int i = 0; i < rd_vals.size() && row_errs == 0; i++) begin
            check_value($sformatf("fifo_read_data_o sample %0d", i), 32'(rd_vals[i]),
                        32'(visible_bits(ramp_sample(base, i, step), row.low_res)));
        end
    endtask

    task automatic run_row(input test_row_t row);
        logic [11:0] trig_val;
        @(posedge adc_sampleclk);
        cfg_i <= '{presamples: row.presamples, max_samples: row.max_samples,
                   downsample: row.downsample};
        read_mode_i <= '{low_res: row.low_res};
        arm_i <= 1'b1;
        repeat (3) @(posedge adc_sampleclk);
        arm_i <= 1'b0;
        @(negedge adc_sampleclk);
        check_value("error_flag_o after arm", 32'(error_flag_o), 32'h0);
        check_value("adc_capture_stop_o after arm", 32'(adc_capture_stop_o), 32'h0);
        check_value("fifo_read_fifoempty_o after arm", 32'(fifo_read_fifoempty_o), 32'h1);
        repeat (row.trig_delay) @(posedge adc_sampleclk);
        trig_val = adc_datain_i + 1'b1;     // ramp value driven with the trigger
        adc_capture_go_i <= 1'b1;
        while (!adc_capture_stop_o) begin
            @(negedge adc_sampleclk);
        end
        @(posedge adc_sampleclk);
        adc_capture_go_i <= 1'b0;
        read_until_empty();
        check_value("error_flag_o after read", 32'(error_flag_o), 32'h0);
        if (row.extra_read) begin
            @(posedge adc_sampleclk);
            fifo_read_fifoen_i <= 1'b1;
            @(posedge adc_sampleclk);
            fifo_read_fifoen_i <= 1'b0;
            @(negedge adc_sampleclk);
            check_value("error_flag_o after bad read", 32'(error_flag_o), 32'h1);
            check_value("fifo_read_data_o after bad read", 32'(fifo_read_data_o), 32'h0);
        end
        decode_samples(row.low_res);
        check_capture(row, trig_val);
    endtask

    // watchdog sized from the table
    initial begin
        int budget;
        budget = 20;
        foreach (rows[r]) begin
            budget += int'(rows[r].max_samples) * (int'(rows[r].downsample) + 1)
                    + int'(rows[r].trig_delay) + 10 * int'(rows[r].max_samples) + 200;
        end
        #(budget * CLK_PERIOD);
        $display("watchdog expired before all tests finished");
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        tests_passed = 0;
        tests_failed = 0;
        repeat (10) @(posedge adc_sampleclk);
        reset <= 1'b0;
        @(negedge adc_sampleclk);
        row_errs = 0;
        check_value("adc_capture_stop_o after reset", 32'(adc_capture_stop_o), 32'h0);
        check_value("error_flag_o after reset", 32'(error_flag_o), 32'h0);
        check_value("fifo_read_fifoempty_o after reset", 32'(fifo_read_fifoempty_o), 32'h1);
        report_test("reset state");
        for (int r = 0; r < NUM_ROWS; r++) begin
            row_errs = 0;
            run_row(rows[r]);
            report_test($sformatf("row %0d (P=%0d N=%0d ds=%0d %s)", r, rows[r].presamples,
                        rows[r].max_samples, rows[r].downsample,
                        rows[r].low_res ? "lo-res" : "hi-res"));
        end
        $display("tests passed %0d failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
